//--- src.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/carry_select_adder.sv
hdl/barrel_shifter.sv
hdl/alu_decode.sv
hdl/alu_execute.sv
hdl/alu_result.sv
hdl/alu_top.sv
test/tb_clock.sv
test/alu_tb.sv

//--- Bender.yml
package:
  name: alu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/alu_pkg.sv
      - hdl/carry_select_adder.sv
      - hdl/barrel_shifter.sv
      - hdl/alu_decode.sv
      - hdl/alu_execute.sv
      - hdl/alu_result.sv
      - hdl/alu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_clock.sv
      - test/alu_tb.sv

//--- test/alu_tb.sv
`default_nettype none

`include "alu_macros.svh"

module alu_tb import alu_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int ACK_LATENCY = 3;
	localparam int RANDOM_TRANS = 300;
	// 1 + 4 + 5 + 16 + 7 directed plus the random ones
	localparam int PLANNED = 33 + RANDOM_TRANS;
	localparam int WAIT_LIMIT = 20;

	logic clock;
	logic rst;
	logic req;
	word_t operand_a;
	word_t operand_b;
	opcode_t opcode;
	shamt_t shamt;
	logic ack;
	word_t result;
	logic is_not_equal;
	logic is_less_than;

	word_t exp_result;
	logic exp_ne;
	logic exp_lt;
	logic ack_prev;
	int pass_count;
	int fail_count;
	int acks_seen;
	int trans_sent;
	int test_fails;
	logic [31:0] rng_state;

	tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clock(clock));

	alu_top uut (
		.clock(clock),
		.rst(rst),
		.req(req),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.opcode(opcode),
		.shamt(shamt),
		.ack(ack),
		.result(result),
		.is_not_equal(is_not_equal),
		.is_less_than(is_less_than)
	);

	// packed as {result, ne, lt}
	function automatic logic [`ALU_WIDTH+1:0] alu_model(input word_t a, input word_t b,
		input opcode_t opc, input shamt_t sh);
		word_t res;
		logic ne;
		logic lt;
		case (opc)
			`ALU_OPC_ADD: res = a + b;
			`ALU_OPC_SUB: res = a - b;
			`ALU_OPC_AND: res = a & b;
			`ALU_OPC_OR: res = a | b;
			`ALU_OPC_SLL: res = a << sh;
			`ALU_OPC_SRA: res = $signed(a) >>> sh;
			default: res = '0;
		endcase
		ne = (a != b);
		lt = ($signed(a) < $signed(b));
		return {res, ne, lt};
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			fail_count++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end else begin
			pass_count++;
		end
	endtask

	task automatic note_failure(input string msg);
		fail_count++;
		$display("failure at %0t: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		$display("test %s finished, %0d failed checks", name, fail_count - test_fails);
		test_fails = fail_count;
	endtask

	// one full four-phase handshake with req held for hold extra cycles after ack
	task automatic run_op(input word_t a, input word_t b, input opcode_t opc,
		input shamt_t sh, input int hold);
		logic [`ALU_WIDTH+1:0] expected;
		int edges;
		expected = alu_model(a, b, opc, sh);
		@(posedge clock);
		exp_result = expected[`ALU_WIDTH+1:2];
		exp_ne = expected[1];
		exp_lt = expected[0];
		operand_a <= a;
		operand_b <= b;
		opcode <= opc;
		shamt <= sh;
		req <= 1'b1;
		trans_sent++;
		// acceptance edge
		@(posedge clock);
		edges = 0;
		while (ack !== 1'b1 && edges < WAIT_LIMIT) begin
			@(posedge clock);
			edges++;
		end
		// ack raised at N+2 is first sampled at N+3
		if (ack !== 1'b1)
			note_failure("no ack after the request was accepted");
		else if (edges != ACK_LATENCY)
			note_failure($sformatf("ack came %0d cycles after acceptance, expected %0d",
				edges, ACK_LATENCY));
		repeat (hold) begin
			@(posedge clock);
			if (ack !== 1'b1)
				note_failure("ack dropped while req was held high");
		end
		req <= 1'b0;
		edges = 0;
		do begin
			@(posedge clock);
			edges++;
		end while (ack !== 1'b0 && edges < WAIT_LIMIT);
		if (ack !== 1'b0)
			note_failure("ack stayed high after req dropped");
		else if (edges != 2)
			note_failure($sformatf("ack fell %0d cycles after req dropped, expected 1",
				edges - 1));
	endtask

	// outputs must match while ack is high
	always @(posedge clock) begin
		if (rst) begin
			ack_prev <= 1'b0;
		end else begin
			if (ack === 1'b1) begin
				if (!ack_prev)
					acks_seen++;
				check_value("result", exp_result, result);
				check_value("is_not_equal", exp_ne, is_not_equal);
				check_value("is_less_than", exp_lt, is_less_than);
			end
			ack_prev <= ack;
		end
	end

	initial begin
		#(PLANNED * WAIT_LIMIT * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", PLANNED * WAIT_LIMIT);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		opcode_t opc;
		word_t shift_vals [0:1];
		opcode_t shift_ops [0:1];
		shamt_t amounts [0:3];
		rst = 1'b1;
		req = 1'b0;
		operand_a = '0;
		operand_b = '0;
		opcode = '0;
		shamt = '0;
		exp_result = '0;
		exp_ne = 1'b0;
		exp_lt = 1'b0;
		pass_count = 0;
		fail_count = 0;
		acks_seen = 0;
		trans_sent = 0;
		test_fails = 0;
		rng_state = 32'h97fc_c82a;
		shift_vals[0] = 32'h1234_5678;
		shift_vals[1] = 32'h8765_4321;
		shift_ops[0] = `ALU_OPC_SLL;
		shift_ops[1] = `ALU_OPC_SRA;
		amounts[0] = 5'd0;
		amounts[1] = 5'd1;
		amounts[2] = 5'd16;
		amounts[3] = 5'd31;

		repeat (RESET_CYCLES) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		check_value("ack", 1'b0, ack);
		check_value("result", '0, result);
		check_value("is_not_equal", 1'b0, is_not_equal);
		check_value("is_less_than", 1'b0, is_less_than);
		run_op(32'd5, 32'd7, `ALU_OPC_ADD, 5'd0, 10);
		end_test("reset and handshake");

		run_op(32'hFFFF_FFFF, 32'd1, `ALU_OPC_ADD, 5'd0, 0);
		run_op(32'd0, 32'd1, `ALU_OPC_SUB, 5'd0, 0);
		run_op(32'h1234_5678, 32'h0FED_CBA9, `ALU_OPC_ADD, 5'd0, 0);
		run_op(32'd100, 32'd58, `ALU_OPC_SUB, 5'd0, 0);
		end_test("add and subtract");

		run_op(32'hF0F0_1234, 32'h0FF0_FF00, `ALU_OPC_AND, 5'd0, 0);
		run_op(32'hF0F0_1234, 32'h0FF0_FF00, `ALU_OPC_OR, 5'd0, 0);
		run_op(32'hDEAD_BEEF, 32'h0000_0001, 5'd6, 5'd3, 0);
		run_op(32'h0000_0001, 32'hDEAD_BEEF, 5'd17, 5'd9, 0);
		run_op(32'h5555_5555, 32'h5555_5555, 5'd31, 5'd31, 0);
		end_test("logic and unused opcodes");

		for (int i = 0; i < 2; i++) begin
			for (int j = 0; j < 2; j++) begin
				for (int k = 0; k < 4; k++)
					run_op(shift_vals[j], 32'h0000_00FF, shift_ops[i], amounts[k], 0);
			end
		end
		end_test("shifts");

		run_op(32'h5A5A_5A5A, 32'h5A5A_5A5A, `ALU_OPC_SUB, 5'd0, 0);
		run_op(32'hFFFF_FFF0, 32'd3, `ALU_OPC_SUB, 5'd0, 0);
		run_op(32'd3, 32'hFFFF_FFF0, `ALU_OPC_SUB, 5'd0, 0);
		run_op(32'hFFFF_FF00, 32'hFFFF_FFF0, `ALU_OPC_SUB, 5'd0, 0);
		run_op(32'd10, 32'd20, `ALU_OPC_SUB, 5'd0, 0);
		// difference overflows in these two
		run_op(32'h8000_0000, 32'd1, `ALU_OPC_SUB, 5'd0, 0);
		run_op(32'h7FFF_FFFF, 32'hFFFF_FFFF, `ALU_OPC_SUB, 5'd0, 0);
		end_test("compare flags");

		for (int n = 0; n < RANDOM_TRANS; n++) begin
			next_random(r0);
			next_random(r1);
			next_random(r2);
			// mostly valid opcodes and some equal operands
			opc = (r2[31:29] != 3'b000) ? opcode_t'(r2 % 6) : r2[4:0];
			if (r2[7:5] == 3'b000)
				r1 = r0;
			run_op(r0, r1, opc, r2[12:8], 0);
		end
		end_test("random");

		if (acks_seen != trans_sent)
			note_failure($sformatf("saw %0d acks for %0d requests", acks_seen, trans_sent));
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

endmodule

`default_nettype wire

//--- hdl/alu_top.sv
`default_nettype none

module alu_top import alu_pkg::*; (
	input wire logic clock,
	input wire logic rst,
	input wire logic req,
	input wire word_t operand_a,
	input wire word_t operand_b,
	input wire opcode_t opcode,
	input wire shamt_t shamt,
	output logic ack,
	output word_t result,
	output logic is_not_equal,
	output logic is_less_than
);

	logic dec_valid;
	alu_op_e dec_op;
	word_t dec_a;
	word_t dec_b;
	shamt_t dec_shamt;

	logic exe_valid;
	word_t exe_result;
	logic exe_ne;
	logic exe_lt;

	alu_decode u_decode (
		.clock(clock),
		.rst(rst),
		.req(req),
		.ack(ack),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.opcode(opcode),
		.shamt(shamt),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_a(dec_a),
		.dec_b(dec_b),
		.dec_shamt(dec_shamt)
	);

	alu_execute u_execute (
		.clock(clock),
		.rst(rst),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_a(dec_a),
		.dec_b(dec_b),
		.dec_shamt(dec_shamt),
		.exe_valid(exe_valid),
		.exe_result(exe_result),
		.exe_ne(exe_ne),
		.exe_lt(exe_lt)
	);

	alu_result u_result (
		.clock(clock),
		.rst(rst),
		.req(req),
		.exe_valid(exe_valid),
		.exe_result(exe_result),
		.exe_ne(exe_ne),
		.exe_lt(exe_lt),
		.ack(ack),
		.result(result),
		.is_not_equal(is_not_equal),
		.is_less_than(is_less_than)
	);

endmodule

`default_nettype wire

//--- hdl/alu_result.sv
`default_nettype none

module alu_result import alu_pkg::*; (
	input wire logic clock,
	input wire logic rst,
	input wire logic req,
	input wire logic exe_valid,
	input wire word_t exe_result,
	input wire logic exe_ne,
	input wire logic exe_lt,
	output logic ack,
	output word_t result,
	output logic is_not_equal,
	output logic is_less_than
);

	res_state_e state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= res_idle;
			ack <= 1'b0;
			result <= '0;
			is_not_equal <= 1'b0;
			is_less_than <= 1'b0;
		end else begin
			case (state)
				res_idle: begin
					if (exe_valid) begin
						result <= exe_result;
						is_not_equal <= exe_ne;
						is_less_than <= exe_lt;
						ack <= 1'b1;
						state <= res_hold;
					end
				end
				res_hold: begin
					// outputs stay put until the next load
					if (!req) begin
						ack <= 1'b0;
						state <= res_idle;
					end
				end
				default: state <= res_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/alu_execute.sv
`default_nettype none

`include "alu_macros.svh"

module alu_execute import alu_pkg::*; (
	input wire logic clock,
	input wire logic rst,
	input wire logic dec_valid,
	input wire alu_op_e dec_op,
	input wire word_t dec_a,
	input wire word_t dec_b,
	input wire shamt_t dec_shamt,
	output logic exe_valid,
	output word_t exe_result,
	output logic exe_ne,
	output logic exe_lt
);

	localparam int MSB = `ALU_WIDTH - 1;

	word_t add_sum;
	word_t sub_diff;
	word_t shift_out;
	word_t result_next;
	logic ne_next;
	logic lt_next;

	carry_select_adder u_add (
		.a(dec_a),
		.b(dec_b),
		.carry_in(1'b0),
		.sum(add_sum),
		.carry_out()
	);

	// a - b as a + ~b + 1
	carry_select_adder u_sub (
		.a(dec_a),
		.b(~dec_b),
		.carry_in(1'b1),
		.sum(sub_diff),
		.carry_out()
	);

	barrel_shifter u_shift (
		.value(dec_a),
		.shamt(dec_shamt),
		.arith_right(dec_op == op_sra),
		.shifted(shift_out)
	);

	always_comb begin
		case (dec_op)
			op_add: result_next = add_sum;
			op_sub: result_next = sub_diff;
			op_and: result_next = dec_a & dec_b;
			op_or: result_next = dec_a | dec_b;
			op_sll, op_sra: result_next = shift_out;
			default: result_next = '0;
		endcase
	end

	assign ne_next = |sub_diff;

	// differing signs decide directly, so overflow never matters
	assign lt_next = (dec_a[MSB] != dec_b[MSB]) ? dec_a[MSB] : sub_diff[MSB];

	always_ff @(posedge clock) begin
		if (rst)
			exe_valid <= 1'b0;
		else
			exe_valid <= dec_valid;
	end

	always_ff @(posedge clock) begin
		if (dec_valid) begin
			exe_result <= result_next;
			exe_ne <= ne_next;
			exe_lt <= lt_next;
		end
	end

endmodule

`default_nettype wire

//--- hdl/alu_decode.sv
`default_nettype none

`include "alu_macros.svh"

module alu_decode import alu_pkg::*; (
	input wire logic clock,
	input wire logic rst,
	input wire logic req,
	input wire logic ack,
	input wire word_t operand_a,
	input wire word_t operand_b,
	input wire opcode_t opcode,
	input wire shamt_t shamt,
	output logic dec_valid,
	output alu_op_e dec_op,
	output word_t dec_a,
	output word_t dec_b,
	output shamt_t dec_shamt
);

	dec_state_e state;
	alu_op_e op_next;
	logic accept;

	// one request per handshake
	assign accept = req && !ack && (state == dec_idle);

	always_comb begin
		case (opcode)
			`ALU_OPC_ADD: op_next = op_add;
			`ALU_OPC_SUB: op_next = op_sub;
			`ALU_OPC_AND: op_next = op_and;
			`ALU_OPC_OR: op_next = op_or;
			`ALU_OPC_SLL: op_next = op_sll;
			`ALU_OPC_SRA: op_next = op_sra;
			default: op_next = op_none;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= dec_idle;
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= accept;
			if (accept)
				state <= dec_busy;
			// ack marks the end of this handshake
			else if (state == dec_busy && ack)
				state <= dec_idle;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			dec_op <= op_next;
			dec_a <= operand_a;
			dec_b <= operand_b;
			dec_shamt <= shamt;
		end
	end

endmodule

`default_nettype wire

//--- hdl/barrel_shifter.sv
`default_nettype none

`include "alu_macros.svh"

module barrel_shifter import alu_pkg::*; (
	input wire word_t value,
	input wire shamt_t shamt,
	input wire logic arith_right,
	output word_t shifted
);

	localparam int W = `ALU_WIDTH;
	localparam int STAGES = `ALU_SHAMT_W;

	// stage[0] is the input, stage[STAGES] the result
	word_t stage [0:STAGES];

	assign stage[0] = value;

	for (genvar s = 0; s < STAGES; s++) begin : g_stage
		localparam int SH = 1 << s;
		word_t moved_left;
		word_t moved_right;

		assign moved_left = {stage[s][W-1-SH:0], {SH{1'b0}}};
		// sign fill comes from the original word
		assign moved_right = {{SH{value[W-1]}}, stage[s][W-1:SH]};

		assign stage[s+1] = !shamt[s] ? stage[s] :
			arith_right ? moved_right : moved_left;
	end

	assign shifted = stage[STAGES];

endmodule

`default_nettype wire

//--- hdl/carry_select_adder.sv
`default_nettype none

`include "alu_macros.svh"

module carry_select_adder import alu_pkg::*; (
	input wire word_t a,
	input wire word_t b,
	input wire logic carry_in,
	output word_t sum,
	output logic carry_out
);

	localparam int NUM_BLOCKS = `ALU_WIDTH / 4;

	// carry[i] enters block i
	logic [NUM_BLOCKS:0] carry;

	// 4-bit ripple with the carry out in bit 4
	function automatic logic [4:0] ripple4(input logic [3:0] x, input logic [3:0] y,
		input logic cin);
		logic [4:0] res;
		logic c;
		c = cin;
		for (int k = 0; k < 4; k++) begin
			res[k] = x[k] ^ y[k] ^ c;
			c = (x[k] & y[k]) | (c & (x[k] ^ y[k]));
		end
		res[4] = c;
		return res;
	endfunction

	assign carry[0] = carry_in;
	assign {carry[1], sum[3:0]} = ripple4(a[3:0], b[3:0], carry[0]);

	for (genvar i = 1; i < NUM_BLOCKS; i++) begin : g_block
		logic [4:0] sum_c0;
		logic [4:0] sum_c1;
		assign sum_c0 = ripple4(a[4*i +: 4], b[4*i +: 4], 1'b0);
		assign sum_c1 = ripple4(a[4*i +: 4], b[4*i +: 4], 1'b1);
		// pick by the carry out of the block below
		assign {carry[i+1], sum[4*i +: 4]} = carry[i] ? sum_c1 : sum_c0;
	end

	assign carry_out = carry[NUM_BLOCKS];

endmodule

`default_nettype wire

//--- hdl/alu_pkg.sv
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

	typedef logic [`ALU_WIDTH-1:0] word_t;
	typedef logic [`ALU_OPC_W-1:0] opcode_t;
	typedef logic [`ALU_SHAMT_W-1:0] shamt_t;

	// decoded operation
	typedef enum logic [2:0] {
		op_add, op_sub, op_and, op_or,
		op_sll, op_sra, op_none
	} alu_op_e;

	typedef enum logic {dec_idle, dec_busy} dec_state_e;

	typedef enum logic {res_idle, res_hold} res_state_e;

endpackage

`default_nettype wire

//--- hdl/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// data path width
`define ALU_WIDTH 32

// control field widths
`define ALU_OPC_W 5
`define ALU_SHAMT_W 5

// opcode encodings 0 to 5
`define ALU_OPC_ADD 5'd0
`define ALU_OPC_SUB 5'd1
`define ALU_OPC_AND 5'd2
`define ALU_OPC_OR 5'd3
`define ALU_OPC_SLL 5'd4
`define ALU_OPC_SRA 5'd5

`endif
